// File: exec_cases.txt
// op a b rd expected, all hex; op codes follow exec_op_e
// rd 00 marks an operation without a register write
0 00000005 00000007 01 0000000c
0 ffffffff 00000001 02 00000000
1 00000003 00000005 03 fffffffe
2 00000001 00000024 04 00000010
2 80000001 0000001f 05 80000000
3 ffffffff 00000001 06 00000001
4 ffffffff 00000001 07 00000000
3 00000001 ffffffff 08 00000000
4 00000001 ffffffff 09 00000001
5 a5a5a5a5 0f0f0f0f 0a aaaaaaaa
6 80000000 00000041 0b 40000000
7 80000000 00000004 0c f8000000
7 7ffffff0 00000004 0d 07ffffff
8 12340000 00005678 0e 12345678
9 ff00ff00 0ff00ff0 0f 0f000f00
0 00000001 00000001 00 00000002
a 00000014 00000006 10 00000003
a ffffffec 00000006 11 fffffffd
a 00000014 fffffffa 12 fffffffd
a ffffffec fffffffa 13 00000003
c ffffffec 00000006 14 fffffffe
c 00000014 fffffffa 15 00000002
b ffffffec 00000006 16 2aaaaaa7
d ffffffec 00000006 17 00000002
b 00000007 00000002 18 00000003
a 00000123 00000000 19 ffffffff
b 00000123 00000000 1a ffffffff
c 00000123 00000000 1b 00000123
d ffffff00 00000000 1c ffffff00
a 80000000 ffffffff 1d 80000000
c 80000000 ffffffff 1e 00000000
b 80000000 ffffffff 1f 00000000
a 7fffffff 00000003 01 2aaaaaaa
0 00000010 00000020 02 00000030
1 00000000 00000001 03 ffffffff
5 ffffffff 12345678 04 edcba987
d 0000000a 00000003 05 00000001
c 80000000 00000003 06 fffffffe
4 00000000 00000000 07 00000000
c 00000009 00000000 00 00000009

// File: exec_collect.sv
`timescale 1ns/1ns

module exec_collect
    import exec_pkg::*;
#(
    parameter int lanes = lanes_default
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [lanes-1:0] res_valid,
    output logic [lanes-1:0] res_ready,
    input  exec_res_t        res [lanes],
    output logic             out_valid,
    input  logic             out_ready,
    output exec_res_t        out
);

    localparam int idx_w = (lanes > 1) ? $clog2(lanes) : 1;

    logic [idx_w-1:0] ptr;
    logic             fire;

    // Same lane order as the dispatcher, so results come back in program order.
    assign out_valid = res_valid[ptr];
    assign out       = res[ptr];
    assign fire      = out_valid && out_ready;

    always_comb begin
        res_ready = '0;
        res_ready[ptr] = out_ready;
    end

    ////////////////////
    // Drain pointer.
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            ptr <= '0;
        end else if (fire) begin
            if (ptr == idx_w'(lanes - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

endmodule

// File: exec_dispatch.sv
`timescale 1ns/1ns

module exec_dispatch
    import exec_pkg::*;
#(
    parameter int lanes = lanes_default
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             op_valid,
    output logic             op_ready,
    input  exec_op_t         op,
    output logic [lanes-1:0] issue_valid,
    output exec_op_t         issue_op,
    input  logic [lanes-1:0] issue_ready
);

    localparam int idx_w = (lanes > 1) ? $clog2(lanes) : 1;

    logic [idx_w-1:0] idx;
    logic             fire;

    // Only the lane under the pointer may take the operation.
    always_comb begin
        issue_valid = '0;
        issue_valid[idx] = op_valid;
    end

    assign op_ready = issue_ready[idx];
    assign issue_op = op;
    assign fire     = op_valid && op_ready;

    ////////////////////
    // Round-robin issue pointer.
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            idx <= '0;
        end else if (fire) begin
            if (idx == idx_w'(lanes - 1)) begin
                idx <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

endmodule

// File: exec_lane.sv
`timescale 1ns/1ns

module exec_lane
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      issue_valid,
    output logic      issue_ready,
    input  exec_op_t  issue_op,
    output logic      res_valid,
    input  logic      res_ready,
    output exec_res_t res
);

    typedef enum logic [1:0] {
        st_idle,
        st_div,
        st_done
    } lane_state_e;

    lane_state_e state;
    exec_res_t   res_q;

    logic        accept;
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  shamt;
    logic [31:0] alu_result;

    logic        is_div;
    logic        is_signed;
    logic        is_rem_op;
    logic        a_neg;
    logic        b_neg;
    logic [31:0] a_mag;
    logic [31:0] b_mag;
    logic        spec_hit;
    logic [31:0] spec_result;

    // Divider datapath.
    logic [31:0] rem_q;
    logic [31:0] quo_q;
    logic [31:0] dsor_q;
    logic [4:0]  cnt_q;
    logic        neg_quo;
    logic        neg_rem;
    logic        rem_sel;
    logic [32:0] rem_shift;
    logic [32:0] diff;
    logic [31:0] rem_next;
    logic [31:0] quo_next;
    logic [31:0] div_final;

    assign issue_ready = (state == st_idle);
    assign res_valid   = (state == st_done);
    assign res         = res_q;
    assign accept      = issue_valid && issue_ready;

    assign a     = issue_op.rdata1;
    assign b     = issue_op.rdata2;
    assign shamt = b[4:0];

    ////////////////////
    // Single-cycle ALU.
    ////////////////////

    always_comb begin
        case (issue_op.op)
            op_add:  alu_result = a + b;
            op_sub:  alu_result = a - b;
            op_sll:  alu_result = a << shamt;
            op_slt:  alu_result = {31'b0, $signed(a) < $signed(b)};
            op_sltu: alu_result = {31'b0, a < b};
            op_xor:  alu_result = a ^ b;
            op_srl:  alu_result = a >> shamt;
            op_sra:  alu_result = $unsigned($signed(a) >>> shamt);
            op_or:   alu_result = a | b;
            op_and:  alu_result = a & b;
            default: alu_result = '0;
        endcase
    end

    ////////////////////
    // Divide setup.
    ////////////////////

    assign is_div    = issue_op.op inside {op_div, op_divu, op_rem, op_remu};
    assign is_signed = issue_op.op inside {op_div, op_rem};
    assign is_rem_op = issue_op.op inside {op_rem, op_remu};
    assign a_neg     = is_signed && a[31];
    assign b_neg     = is_signed && b[31];
    assign a_mag     = a_neg ? -a : a;
    assign b_mag     = b_neg ? -b : b;

    // Divide by zero and signed overflow skip the iteration.
    always_comb begin
        spec_hit    = 1'b0;
        spec_result = '0;
        if (b == '0) begin
            spec_hit    = 1'b1;
            spec_result = is_rem_op ? a : '1;
        end else if (is_signed && a == 32'h8000_0000 && b == '1) begin
            spec_hit    = 1'b1;
            spec_result = is_rem_op ? '0 : a;
        end
    end

    // One restoring step per cycle.
    assign rem_shift = {rem_q, quo_q[31]};
    assign diff      = rem_shift - {1'b0, dsor_q};
    assign rem_next  = diff[32] ? rem_shift[31:0] : diff[31:0];
    assign quo_next  = {quo_q[30:0], ~diff[32]};

    always_comb begin
        if (rem_sel) begin
            div_final = neg_rem ? -rem_next : rem_next;
        end else begin
            div_final = neg_quo ? -quo_next : quo_next;
        end
    end

    ////////////////////
    // Lane control.
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= st_idle;
            cnt_q <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        cnt_q <= '0;
                        if (is_div && !spec_hit) begin
                            state <= st_div;
                        end else begin
                            state <= st_done;
                        end
                    end
                end
                st_div: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == 5'd31) begin
                        state <= st_done;
                    end
                end
                default: begin
                    if (res_ready) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res_q.waddr <= issue_op.waddr;
            res_q.wren  <= issue_op.wren;
            res_q.wdata <= is_div ? spec_result : alu_result;
            rem_q       <= '0;
            quo_q       <= a_mag;
            dsor_q      <= b_mag;
            neg_quo     <= a_neg ^ b_neg;
            neg_rem     <= a_neg;
            rem_sel     <= is_rem_op;
        end else if (state == st_div) begin
            rem_q <= rem_next;
            quo_q <= quo_next;
            if (cnt_q == 5'd31) begin
                res_q.wdata <= div_final;
            end
        end
    end

endmodule

// File: exec_pkg.sv
package exec_pkg;

    // Default number of execute lanes.
    localparam int lanes_default = 4;

    ////////////////////
    // Operation encoding.
    ////////////////////

    typedef enum logic [3:0] {
        op_add  = 4'h0,
        op_sub  = 4'h1,
        op_sll  = 4'h2,
        op_slt  = 4'h3,
        op_sltu = 4'h4,
        op_xor  = 4'h5,
        op_srl  = 4'h6,
        op_sra  = 4'h7,
        op_or   = 4'h8,
        op_and  = 4'h9,
        op_div  = 4'ha,
        op_divu = 4'hb,
        op_rem  = 4'hc,
        op_remu = 4'hd
    } exec_op_e;

    ////////////////////
    // Stream payloads.
    ////////////////////

    // Decoded operation with both operands read.
    typedef struct packed {
        exec_op_e    op;
        logic [31:0] rdata1;
        logic [31:0] rdata2;
        logic [4:0]  waddr;
        logic        wren;
    } exec_op_t;

    // Result headed for writeback.
    typedef struct packed {
        logic [31:0] wdata;
        logic [4:0]  waddr;
        logic        wren;
    } exec_res_t;

endpackage

// File: execute_cluster.f
exec_pkg.sv
exec_dispatch.sv
exec_lane.sv
exec_collect.sv
execute_cluster.sv
tb_execute_cluster.sv

// File: execute_cluster.sv
`timescale 1ns/1ns

module execute_cluster
    import exec_pkg::*;
#(
    parameter int lanes = lanes_default
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      op_valid,
    output logic      op_ready,
    input  exec_op_t  op,
    output logic      out_valid,
    input  logic      out_ready,
    output exec_res_t out
);

    logic [lanes-1:0] issue_valid;
    logic [lanes-1:0] issue_ready;
    exec_op_t         issue_op;
    logic [lanes-1:0] res_valid;
    logic [lanes-1:0] res_ready;
    exec_res_t        lane_res [lanes];

    exec_dispatch #(
        .lanes(lanes)
    ) i_dispatch (
        .clk        (clk),
        .rst        (rst),
        .op_valid   (op_valid),
        .op_ready   (op_ready),
        .op         (op),
        .issue_valid(issue_valid),
        .issue_op   (issue_op),
        .issue_ready(issue_ready)
    );

    // One lane per in-flight operation.
    for (genvar i = 0; i < lanes; i++) begin : g_lane
        exec_lane i_lane (
            .clk        (clk),
            .rst        (rst),
            .issue_valid(issue_valid[i]),
            .issue_ready(issue_ready[i]),
            .issue_op   (issue_op),
            .res_valid  (res_valid[i]),
            .res_ready  (res_ready[i]),
            .res        (lane_res[i])
        );
    end

    exec_collect #(
        .lanes(lanes)
    ) i_collect (
        .clk      (clk),
        .rst      (rst),
        .res_valid(res_valid),
        .res_ready(res_ready),
        .res      (lane_res),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out      (out)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the execute cluster testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_execute_cluster \
    -f execute_cluster.f \
    -o tb_execute_cluster

result=$(./obj_dir/tb_execute_cluster)
echo "$result"

if echo "$result" | grep -Fqx '>>> PASS'; then
    exit 0
fi
exit 1

// File: tb_execute_cluster.sv
`timescale 1ns/1ns

module tb_execute_cluster
    import exec_pkg::*;
();

    localparam int lanes        = 4;
    localparam int half_period  = 20;
    localparam int drive_dly    = 2;
    localparam int wait_limit   = 200;
    localparam int drain_cycles = 40;

    logic      clk;
    logic      rst;
    logic      op_valid;
    logic      op_ready;
    exec_op_t  op;
    logic      out_valid;
    logic      out_ready;
    exec_res_t out;

    exec_op_t    op_q[$];
    exec_res_t   exp_q[$];
    int          value_errs;
    int          other_errs;
    int          n_cases;
    int          n_out;

    execute_cluster #(
        .lanes(lanes)
    ) i_dut (
        .clk      (clk),
        .rst      (rst),
        .op_valid (op_valid),
        .op_ready (op_ready),
        .op       (op),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out      (out)
    );

    always #half_period clk = ~clk;

    ////////////////////
    // Case file.
    ////////////////////

    // Register 0 carries no write.
    task automatic read_cases();
        int          fd;
        int          n;
        string       line;
        logic [3:0]  code;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  rd;
        logic [31:0] expected;
        exec_op_t    o;
        exec_res_t   r;
        fd = $fopen("exec_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open exec_cases.txt");
            other_errs++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%h %h %h %h %h", code, a, b, rd, expected) == 5) begin
                o.op     = exec_op_e'(code);
                o.rdata1 = a;
                o.rdata2 = b;
                o.waddr  = rd;
                o.wren   = (rd != 5'd0);
                r.wdata  = expected;
                r.waddr  = rd;
                r.wren   = (rd != 5'd0);
                op_q.push_back(o);
                exp_q.push_back(r);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_res(input exec_res_t got, input exec_res_t expected);
        if (got.wdata !== expected.wdata) begin
            $display("ERROR %0t out.wdata got %h expected %h", $time, got.wdata, expected.wdata);
            value_errs++;
        end
        if (got.waddr !== expected.waddr) begin
            $display("ERROR %0t out.waddr got %h expected %h", $time, got.waddr, expected.waddr);
            value_errs++;
        end
        if (got.wren !== expected.wren) begin
            $display("ERROR %0t out.wren got %b expected %b", $time, got.wren, expected.wren);
            value_errs++;
        end
    endtask

    ////////////////////
    // Input and output streams.
    ////////////////////

    // Entered and left a little after each rising edge.
    task automatic drive_ops();
        int waited;
        for (int i = 0; i < n_cases; i++) begin
            op_valid = 1'b1;
            op       = op_q[i];
            waited   = 0;
            while (!op_ready && waited < wait_limit) begin
                @(posedge clk);
                #drive_dly;
                waited++;
            end
            if (!op_ready) begin
                $display("Timeout: op_ready stayed low for case %0d", i);
                other_errs++;
                break;
            end
            @(posedge clk);
            #drive_dly;
        end
        op_valid = 1'b0;
    endtask

    task automatic collect_results();
        int        idle;
        exec_res_t expected;
        idle = 0;
        while (n_out < n_cases) begin
            @(posedge clk);
            #drive_dly;
            out_ready = ($urandom % 4) != 0;
            if (out_valid && out_ready) begin
                expected = exp_q.pop_front();
                check_res(out, expected);
                n_out++;
                idle = 0;
            end else begin
                idle++;
                if (idle > wait_limit) begin
                    $display("Timeout: no result %0d of %0d arrived", n_out, n_cases);
                    other_errs++;
                    break;
                end
            end
        end
        // Nothing may follow the last result.
        repeat (drain_cycles) begin
            @(posedge clk);
            #drive_dly;
            out_ready = 1'b1;
            if (out_valid) begin
                $display("Unexpected extra result after the last case");
                other_errs++;
                break;
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b0;
        op_valid   = 1'b0;
        op         = '0;
        out_ready  = 1'b0;
        value_errs = 0;
        other_errs = 0;
        n_out      = 0;
        void'($urandom(32'hfee63ab3));
        read_cases();
        n_cases = op_q.size();
        if (n_cases == 0) begin
            $display("No cases were read from exec_cases.txt");
            other_errs++;
        end
        repeat (5) @(posedge clk);
        #drive_dly;
        rst = 1'b1;
        if (!op_ready || out_valid) begin
            $display("Cluster is not idle after reset");
            other_errs++;
        end
        fork
            drive_ops();
            collect_results();
        join
        if (n_out != n_cases) begin
            $display("Got %0d results for %0d cases", n_out, n_cases);
            other_errs++;
        end
        $display("Errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
